// File: Bender.yml
package:
  name: prefix_scan_fabric

export_include_dirs:
  - common

sources:
  # design, in compile order
  - include_dirs:
      - common
    files:
      - common/scan_types_pkg.sv
      - common/lane_pkg.sv
      - hw/prefix_scan.sv
      - hw/scan_fabric/scan_dispatch.sv
      - hw/scan_fabric/scan_lane.sv
      - hw/scan_fabric/scan_collect.sv
      - hw/scan_fabric/scan_fabric_top.sv

  # testbench, top module scan_fabric_tb
  - target: test
    include_dirs:
      - common
    files:
      - sim/scan_checker.sv
      - sim/scan_properties.sv
      - sim/scan_fabric_tb.sv

// File: common/lane_pkg.sv
/*
 * Internal formats between dispatch, the lanes and the collector.
 * Everything here is already in hi-to-lo bit order.
 */

package lane_pkg;

`include "scan_macros.svh"

   import scan_types_pkg::scan_op_e;

   // one segment handed to a lane
   typedef struct packed
   {
      logic [`SCAN_SEG_WIDTH-1:0] seg;
      // operator travels with the segment so the lane can pick a core
      scan_op_e                   op;
   } seg_req_t;

   // lane result
   typedef struct packed
   {
      // local scan of the segment, no carry from upper lanes yet
      logic [`SCAN_SEG_WIDTH-1:0] seg;
      // operator over the whole segment
      // same as bit 0 of the local scan
      logic                       red;
   } lane_out_t;

endpackage

// File: common/scan_macros.svh
/*
 * Size constants for the 64-bit prefix-scan fabric.
 * Included by both packages and by every RTL file that sizes a bus.
 * The segment width follows from the word width and the lane count.
 */

`ifndef SCAN_MACROS_SVH
`define SCAN_MACROS_SVH

// full request word, bit 63 is the top of a hi-to-lo scan
`define SCAN_WIDTH 64

// number of parallel lanes in the fabric
// the word width has to be a multiple of this
`define SCAN_LANES 4

// bits handled by one lane
// each lane scans its own slice and reports the slice reduction
`define SCAN_SEG_WIDTH (`SCAN_WIDTH / `SCAN_LANES)

// the collector scans the lane reductions at SCAN_LANES width
// so a lane count of 1 degenerates to a plain single-lane scan
// and larger counts only add rows to that small scan

`endif

// File: common/scan_types_pkg.sv
/*
 * Request and response formats seen at the fabric boundary.
 * Also holds the operator encoding that every stage decodes.
 */

package scan_types_pkg;

`include "scan_macros.svh"

   // operator carried with each request
   // code 2'b11 is unused and decodes as or
   typedef enum logic [1:0]
   {
      scan_xor = 2'd0,
      scan_and = 2'd1,
      scan_or  = 2'd2
   } scan_op_e;

   // one request, sampled on an in_valid strobe
   typedef struct packed
   {
      logic [`SCAN_WIDTH-1:0] data;
      // reduction operator
      scan_op_e               op;
      // 1 scans from bit 0 upward, 0 scans from bit 63 downward
      logic                   lo_to_hi;
   } scan_req_t;

   // result word, valid with out_valid
   typedef struct packed
   {
      logic [`SCAN_WIDTH-1:0] data;
   } scan_rsp_t;

endpackage

// File: hw/prefix_scan.sv
/*
 * Combinational log-depth prefix scan with a fixed operator and direction.
 * Instantiate one per operator when the operator is picked at run time.
 * Used at segment width in the lanes and at lane-count width in the collector.
 */

`timescale 1ns/1ns

module prefix_scan
   import scan_types_pkg::*;
#(
   parameter int       width_p    = 4,
   parameter scan_op_e op_p       = scan_xor,
   parameter bit       lo_to_hi_p = 1'b0
)
(
   input  logic [width_p-1:0] in_data,
   output logic [width_p-1:0] out_data
);

   // rows needed to cover the whole word
   localparam int rows_lp = $clog2(width_p);

   // identity shifted in from the top
   // and needs ones, xor and or need zeros
   localparam logic fill_lp = (op_p == scan_and);

   // row 0 is the input in hi-to-lo order
   logic [rows_lp:0][width_p-1:0] t;

   // reverse the input so the rows always run from the top bit down
   if (lo_to_hi_p)
   begin : g_rev_in
      assign t[0] = {<<{in_data}};
   end
   else
   begin : g_fwd_in
      assign t[0] = in_data;
   end

   // row j+1 merges row j with itself shifted down by 2**j
   for (genvar j = 0; j < rows_lp; j++)
   begin : g_row
      logic [2*width_p-1:0] ext;

      // identity bits above the word fall into the vacated top positions
      assign ext = {{width_p{fill_lp}}, t[j]} >> (1 << j);

      case (op_p)
         scan_xor:
         begin : g_xor
            assign t[j+1] = t[j] ^ ext[width_p-1:0];
         end
         scan_and:
         begin : g_and
            assign t[j+1] = t[j] & ext[width_p-1:0];
         end
         default:
         begin : g_or
            assign t[j+1] = t[j] | ext[width_p-1:0];
         end
      endcase
   end

   // put the bits back in the caller's order
   if (lo_to_hi_p)
   begin : g_rev_out
      assign out_data = {<<{t[rows_lp]}};
   end
   else
   begin : g_fwd_out
      assign out_data = t[rows_lp];
   end

endmodule

// File: hw/scan_fabric/scan_collect.sv
/*
 * Output stage of the scan fabric.
 * Scans the lane reductions to find each lane's carry from the lanes above,
 * merges the carry into every segment, mirrors lo-to-hi results back and
 * registers the response.
 */

`timescale 1ns/1ns

`include "scan_macros.svh"

module scan_collect
   import scan_types_pkg::*;
   import lane_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_n,
   input  logic [`SCAN_LANES-1:0]       lane_valid,
   input  lane_out_t [`SCAN_LANES-1:0]  lanes,
   input  scan_op_e                     op,
   input  logic                         lo_to_hi,
   output logic                         out_valid,
   output scan_rsp_t                    out_rsp
);

   // op and direction delayed one cycle to line up with the lane registers
   scan_op_e               op_q;
   logic                   dir_q;

   // lane reductions, lane 3 holds the top segment
   logic [`SCAN_LANES-1:0] red;
   logic [`SCAN_LANES-1:0] incl_xor;
   logic [`SCAN_LANES-1:0] incl_and;
   logic [`SCAN_LANES-1:0] incl_or;
   // inclusive scan for the active op
   logic [`SCAN_LANES-1:0] incl;
   logic                   ident;
   // op over all strictly higher lanes
   logic [`SCAN_LANES-1:0] carry;
   logic [`SCAN_WIDTH-1:0] fixed;
   // fixed word in mirrored bit order
   logic [`SCAN_WIDTH-1:0] fixed_rev;
   logic [`SCAN_WIDTH-1:0] word;

   always_ff @(posedge clk_i)
   begin
      op_q  <= op;
      dir_q <= lo_to_hi;
   end

   always_comb
   begin
      for (int l = 0; l < `SCAN_LANES; l++)
         red[l] = lanes[l].red;
   end

   prefix_scan #(.width_p(`SCAN_LANES), .op_p(scan_xor), .lo_to_hi_p(1'b0)) u_xor
   (
      .in_data  (red),
      .out_data (incl_xor)
   );

   prefix_scan #(.width_p(`SCAN_LANES), .op_p(scan_and), .lo_to_hi_p(1'b0)) u_and
   (
      .in_data  (red),
      .out_data (incl_and)
   );

   prefix_scan #(.width_p(`SCAN_LANES), .op_p(scan_or), .lo_to_hi_p(1'b0)) u_or
   (
      .in_data  (red),
      .out_data (incl_or)
   );

   // pick the inclusive scan and the identity for the active op
   always_comb
   begin
      case (op_q)
         scan_xor:
         begin
            incl  = incl_xor;
            ident = 1'b0;
         end
         scan_and:
         begin
            incl  = incl_and;
            ident = 1'b1;
         end
         default:
         begin
            incl  = incl_or;
            ident = 1'b0;
         end
      endcase
   end

   // shift down one lane, the top lane sees only the identity
   assign carry = {ident, incl[`SCAN_LANES-1:1]};

   // fold the carry into every bit of the segment
   always_comb
   begin
      for (int l = 0; l < `SCAN_LANES; l++)
      begin
         case (op_q)
            scan_xor:
               fixed[l*`SCAN_SEG_WIDTH +: `SCAN_SEG_WIDTH] =
                  lanes[l].seg ^ {`SCAN_SEG_WIDTH{carry[l]}};
            scan_and:
               fixed[l*`SCAN_SEG_WIDTH +: `SCAN_SEG_WIDTH] =
                  lanes[l].seg & {`SCAN_SEG_WIDTH{carry[l]}};
            default:
               fixed[l*`SCAN_SEG_WIDTH +: `SCAN_SEG_WIDTH] =
                  lanes[l].seg | {`SCAN_SEG_WIDTH{carry[l]}};
         endcase
      end
   end

   assign fixed_rev = {<<{fixed}};

   // undo the dispatch mirror
   assign word = dir_q ? fixed_rev : fixed;

   // all lanes move in lockstep so their valids agree
   always_ff @(posedge clk_i)
   begin
      if (!rst_n)
         out_valid <= 1'b0;
      else
         out_valid <= &lane_valid;
   end

   always_ff @(posedge clk_i)
   begin
      out_rsp.data <= word;
   end

endmodule

// File: hw/scan_fabric/scan_dispatch.sv
/*
 * Input stage of the scan fabric.
 * Registers one request per cycle, mirrors lo-to-hi words and slices the
 * word into per-lane segments. Everything downstream works hi-to-lo.
 */

`timescale 1ns/1ns

`include "scan_macros.svh"

module scan_dispatch
   import scan_types_pkg::*;
   import lane_pkg::*;
(
   input  logic                              clk_i,
   input  logic                              rst_n,
   input  logic                              in_valid,
   input  scan_req_t                         in_req,
   output logic                              seg_valid,
   output seg_req_t [`SCAN_LANES-1:0]        segs,
   output scan_op_e                          op,
   output logic                              lo_to_hi
);

   // request word in mirrored bit order
   logic [`SCAN_WIDTH-1:0] data_rev;
   // word after optional mirroring
   logic [`SCAN_WIDTH-1:0] word_d;
   logic [`SCAN_WIDTH-1:0] word_q;

   assign data_rev = {<<{in_req.data}};

   // a lo-to-hi scan is a hi-to-lo scan of the mirrored word
   assign word_d = in_req.lo_to_hi ? data_rev : in_req.data;

   // valid is the only control state here
   always_ff @(posedge clk_i)
   begin
      if (!rst_n)
         seg_valid <= 1'b0;
      else
         seg_valid <= in_valid;
   end

   // payload follows every cycle, qualified by seg_valid
   always_ff @(posedge clk_i)
   begin
      word_q   <= word_d;
      op       <= in_req.op;
      lo_to_hi <= in_req.lo_to_hi;
   end

   // lane s gets bits 16s+15 down to 16s
   always_comb
   begin
      for (int s = 0; s < `SCAN_LANES; s++)
      begin
         segs[s].seg = word_q[s*`SCAN_SEG_WIDTH +: `SCAN_SEG_WIDTH];
         segs[s].op  = op;
      end
   end

endmodule

// File: hw/scan_fabric/scan_fabric_top.sv
/*
 * Top of the pipelined 64-bit prefix-scan unit.
 * One request per cycle on in_valid, result on out_valid three cycles later.
 * There is no back-pressure, the consumer takes every response.
 */

`timescale 1ns/1ns

`include "scan_macros.svh"

module scan_fabric_top
   import scan_types_pkg::*;
   import lane_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n,
   input  logic      in_valid,
   input  scan_req_t in_req,
   output logic      out_valid,
   output scan_rsp_t out_rsp
);

   // dispatch to lanes
   logic                          seg_valid;
   seg_req_t [`SCAN_LANES-1:0]    segs;
   // dispatch straight to the collector
   scan_op_e                      op;
   logic                          lo_to_hi;
   // lanes to collector
   logic [`SCAN_LANES-1:0]        lane_valid;
   lane_out_t [`SCAN_LANES-1:0]   lane_out;

   scan_dispatch u_dispatch
   (
      .clk_i     (clk_i),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_req    (in_req),
      .seg_valid (seg_valid),
      .segs      (segs),
      .op        (op),
      .lo_to_hi  (lo_to_hi)
   );

   for (genvar s = 0; s < `SCAN_LANES; s++)
   begin : g_lane
      scan_lane u_lane
      (
         .clk_i      (clk_i),
         .rst_n      (rst_n),
         .seg_valid  (seg_valid),
         .seg        (segs[s]),
         .lane_valid (lane_valid[s]),
         .lane_out   (lane_out[s])
      );
   end

   scan_collect u_collect
   (
      .clk_i      (clk_i),
      .rst_n      (rst_n),
      .lane_valid (lane_valid),
      .lanes      (lane_out),
      .op         (op),
      .lo_to_hi   (lo_to_hi),
      .out_valid  (out_valid),
      .out_rsp    (out_rsp)
   );

endmodule

// File: hw/scan_fabric/scan_lane.sv
/*
 * One lane of the scan fabric.
 * Scans its segment hi-to-lo with all three operators in parallel, keeps the
 * one the request asked for and registers it with the segment reduction.
 */

`timescale 1ns/1ns

`include "scan_macros.svh"

module scan_lane
   import scan_types_pkg::*;
   import lane_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n,
   input  logic      seg_valid,
   input  seg_req_t  seg,
   output logic      lane_valid,
   output lane_out_t lane_out
);

   // core outputs, one per operator
   logic [`SCAN_SEG_WIDTH-1:0] scan_xor_q;
   logic [`SCAN_SEG_WIDTH-1:0] scan_and_q;
   logic [`SCAN_SEG_WIDTH-1:0] scan_or_q;
   // the one that matches the request
   logic [`SCAN_SEG_WIDTH-1:0] scan_sel;

   prefix_scan #(.width_p(`SCAN_SEG_WIDTH), .op_p(scan_xor), .lo_to_hi_p(1'b0)) u_xor
   (
      .in_data  (seg.seg),
      .out_data (scan_xor_q)
   );

   prefix_scan #(.width_p(`SCAN_SEG_WIDTH), .op_p(scan_and), .lo_to_hi_p(1'b0)) u_and
   (
      .in_data  (seg.seg),
      .out_data (scan_and_q)
   );

   prefix_scan #(.width_p(`SCAN_SEG_WIDTH), .op_p(scan_or), .lo_to_hi_p(1'b0)) u_or
   (
      .in_data  (seg.seg),
      .out_data (scan_or_q)
   );

   // unused op code falls to or
   always_comb
   begin
      case (seg.op)
         scan_xor: scan_sel = scan_xor_q;
         scan_and: scan_sel = scan_and_q;
         default:  scan_sel = scan_or_q;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n)
         lane_valid <= 1'b0;
      else
         lane_valid <= seg_valid;
   end

   // bit 0 of a hi-to-lo scan already covers the whole segment
   always_ff @(posedge clk_i)
   begin
      lane_out.seg <= scan_sel;
      lane_out.red <= scan_sel[0];
   end

endmodule

// File: sim/scan_checker.sv
/*
 * Scoreboard for the prefix-scan fabric.
 * Watches the request and response ports, models every scan bit by bit and
 * compares each out_valid beat against the oldest outstanding expectation.
 */

`timescale 1ns/1ns

`include "scan_macros.svh"

module scan_checker
   import scan_types_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n,
   input  logic      in_valid,
   input  scan_req_t in_req,
   input  logic      out_valid,
   input  scan_rsp_t out_rsp,
   output int        checks,
   output int        errors,
   output int        pending
);

   // expected words and the cycle each request was sampled in
   logic [`SCAN_WIDTH-1:0] exp_q[$];
   int                     stamp_q[$];
   int                     cycle;
   logic [`SCAN_WIDTH-1:0] want;
   int                     stamp;

   // walk from the chosen end, bit k holds the op over everything up to k
   function automatic logic [`SCAN_WIDTH-1:0] expected_scan(input scan_req_t r);
      logic [`SCAN_WIDTH-1:0] res;
      logic                   acc;
      int                     k;
      // start from the identity so the first bit passes through
      acc = (r.op == scan_and);
      for (int i = 0; i < `SCAN_WIDTH; i++)
      begin
         k = r.lo_to_hi ? i : `SCAN_WIDTH - 1 - i;
         case (r.op)
            scan_xor: acc = acc ^ r.data[k];
            scan_and: acc = acc & r.data[k];
            default:  acc = acc | r.data[k];
         endcase
         res[k] = acc;
      end
      return res;
   endfunction

   initial
   begin
      checks  = 0;
      errors  = 0;
      pending = 0;
      cycle   = 0;
   end

   always @(posedge clk_i)
   begin
      cycle++;
      if (!rst_n)
      begin
         // anything in flight is lost on reset
         exp_q.delete();
         stamp_q.delete();
      end
      else
      begin
         if (out_valid)
         begin
            if (exp_q.size() == 0)
            begin
               $display("error at %0t: out_valid high with no request outstanding", $time);
               errors++;
            end
            else
            begin
               want  = exp_q.pop_front();
               stamp = stamp_q.pop_front();
               checks++;
               if (out_rsp.data !== want)
               begin
                  $display("error at %0t: out_rsp.data expected %h got %h",
                           $time, want, out_rsp.data);
                  errors++;
               end
               if (cycle - stamp != 3)
               begin
                  $display("error at %0t: result came %0d cycles after its request, not 3",
                           $time, cycle - stamp);
                  errors++;
               end
            end
         end
         // pushed after the pop, a request never meets its own result here
         if (in_valid)
         begin
            exp_q.push_back(expected_scan(in_req));
            stamp_q.push_back(cycle);
         end
      end
      pending = exp_q.size();
   end

endmodule

// File: sim/scan_fabric_tb.sv
/*
 * Testbench for the prefix-scan fabric.
 * Drives seeded random requests through six short tests and leaves the
 * comparison to scan_checker; prints one line per test and a summary.
 */

`timescale 1ns/1ns

`include "scan_macros.svh"

module scan_fabric_tb
   import scan_types_pkg::*;
();

   logic      clk_i;
   logic      rst_n;
   logic      in_valid;
   scan_req_t in_req;
   logic      out_valid;
   scan_rsp_t out_rsp;

   // checker counters
   int chk_checks;
   int chk_errors;
   int chk_pending;
   // failures seen by the testbench itself
   int tb_errors;
   int tests;
   int base_checks;
   int base_errors;
   int total;

   scan_fabric_top dut (.*);

   scan_checker u_checker
   (
      .clk_i     (clk_i),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_req    (in_req),
      .out_valid (out_valid),
      .out_rsp   (out_rsp),
      .checks    (chk_checks),
      .errors    (chk_errors),
      .pending   (chk_pending)
   );

   always #4 clk_i = ~clk_i;

   // inputs change 1 ns after the edge, well clear of sampling
   task automatic step();
      @(posedge clk_i);
      #1;
   endtask

   // one cycle of valid, the next send can follow without a gap
   task automatic send(input logic [`SCAN_WIDTH-1:0] data, input scan_op_e op,
                       input logic dir);
      in_valid        = 1'b1;
      in_req.data     = data;
      in_req.op       = op;
      in_req.lo_to_hi = dir;
      step();
      in_valid = 1'b0;
   endtask

   // nothing outstanding, so out_valid must stay low
   task automatic expect_idle(input int cycles);
      repeat (cycles)
      begin
         step();
         if (out_valid !== 1'b0)
         begin
            $display("error at %0t: out_valid expected 0 got %b", $time, out_valid);
            tb_errors++;
         end
      end
   endtask

   task automatic start_test();
      base_checks = chk_checks;
      base_errors = chk_errors + tb_errors;
   endtask

   // bounded wait for the last results, then the per-test line
   task automatic finish_test(input string name);
      int n;
      n = 0;
      while (chk_pending != 0 && n < 20)
      begin
         step();
         n++;
      end
      if (chk_pending != 0)
      begin
         $display("timeout in %s: %0d results never appeared", name, chk_pending);
         tb_errors++;
      end
      tests++;
      $display("test %0d %s: %0d results, %0d errors", tests, name,
               chk_checks - base_checks, chk_errors + tb_errors - base_errors);
   endtask

   // long runs of one value, broken at up to two random places
   function automatic logic [`SCAN_WIDTH-1:0] biased_word(input logic ones);
      logic [`SCAN_WIDTH-1:0] w;
      w = {`SCAN_WIDTH{ones}};
      repeat ($urandom_range(2, 0))
         w[$urandom_range(`SCAN_WIDTH-1, 0)] = ~ones;
      return w;
   endfunction

   function automatic logic [`SCAN_WIDTH-1:0] random_word();
      return {$urandom(), $urandom()};
   endfunction

   initial
   begin
      void'($urandom(16500));
      clk_i     = 1'b0;
      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_req    = '0;
      tb_errors = 0;
      tests     = 0;

      // reset, then a quiet pipeline
      start_test();
      expect_idle(8);
      rst_n = 1'b1;
      expect_idle(12);
      finish_test("reset and idle");

      // xor hi-to-lo is gray to binary
      start_test();
      repeat (40)
         send(random_word(), scan_xor, 1'b0);
      finish_test("gray to binary");

      // and/or with runs that cross the 16-bit segment edges
      start_test();
      repeat (48)
      begin
         if ($urandom_range(3, 0) == 0)
            send(random_word(), $urandom_range(1, 0) ? scan_and : scan_or, 1'b0);
         else
            send(biased_word($urandom_range(1, 0)),
                 $urandom_range(1, 0) ? scan_and : scan_or, 1'b0);
      end
      finish_test("and or run lengths");

      // mirrored direction for every operator
      start_test();
      repeat (48)
      begin
         if ($urandom_range(1, 0))
            send(random_word(), scan_op_e'($urandom_range(2, 0)), 1'b1);
         else
            send(biased_word($urandom_range(1, 0)), scan_op_e'($urandom_range(2, 0)), 1'b1);
      end
      finish_test("lo to hi");

      // full-rate burst, then sparse strobes
      start_test();
      repeat (32)
         send(random_word(), scan_op_e'($urandom_range(2, 0)), $urandom_range(1, 0));
      repeat (40)
      begin
         repeat ($urandom_range(3, 0))
            step();
         send(biased_word($urandom_range(1, 0)), scan_op_e'($urandom_range(2, 0)),
              $urandom_range(1, 0));
      end
      finish_test("burst and gaps");

      // request on the very first cycle out of reset
      start_test();
      rst_n = 1'b0;
      repeat (8)
         step();
      rst_n = 1'b1;
      send(random_word(), scan_op_e'($urandom_range(2, 0)), $urandom_range(1, 0));
      finish_test("request after reset");
      expect_idle(6);

      total = chk_errors + tb_errors + dut.u_props.assert_fails;
      $display("%0d tests, %0d results checked, %0d errors", tests, chk_checks, total);
      if (total == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// File: sim/scan_properties.sv
/*
 * Concurrent checks bound into the fabric top level.
 * Covers the fixed three-cycle valid latency, the reset value of out_valid
 * and the pass-through of the first scanned bit.
 */

`timescale 1ns/1ns

`include "scan_macros.svh"

module scan_properties
   import scan_types_pkg::*;
(
   input logic      clk_i,
   input logic      rst_n,
   input logic      in_valid,
   input scan_req_t in_req,
   input logic      out_valid,
   input scan_rsp_t out_rsp
);

   // number of failed assertions so far
   int assert_fails = 0;

   // valid rides the three pipeline stages with no gaps or bubbles
   a_latency: assert property (@(posedge clk_i) disable iff (!rst_n)
      out_valid == $past(in_valid, 3))
   else
   begin
      $error("out_valid is not in_valid delayed by three cycles");
      assert_fails++;
   end

   // synchronous reset clears the output valid on the next edge
   a_reset: assert property (@(posedge clk_i) !rst_n |=> !out_valid)
   else
   begin
      $error("out_valid high after a reset edge");
      assert_fails++;
   end

   // hi-to-lo keeps the top bit
   a_top_bit: assert property (@(posedge clk_i) disable iff (!rst_n)
      in_valid && !in_req.lo_to_hi |->
         ##3 out_rsp.data[`SCAN_WIDTH-1] == $past(in_req.data[`SCAN_WIDTH-1], 3))
   else
   begin
      $error("top bit of a hi-to-lo result differs from the request");
      assert_fails++;
   end

   // lo-to-hi keeps bit 0
   a_low_bit: assert property (@(posedge clk_i) disable iff (!rst_n)
      in_valid && in_req.lo_to_hi |-> ##3 out_rsp.data[0] == $past(in_req.data[0], 3))
   else
   begin
      $error("bit 0 of a lo-to-hi result differs from the request");
      assert_fails++;
   end

endmodule

bind scan_fabric_top scan_properties u_props (.*);

// File: sources.f
+incdir+common
common/scan_types_pkg.sv
common/lane_pkg.sv
hw/prefix_scan.sv
hw/scan_fabric/scan_dispatch.sv
hw/scan_fabric/scan_lane.sv
hw/scan_fabric/scan_collect.sv
hw/scan_fabric/scan_fabric_top.sv
sim/scan_checker.sv
sim/scan_properties.sv
sim/scan_fabric_tb.sv
